// ==== compile.f ====
+incdir+.
fpu_pkg.sv
fiu_cvt.sv
fiu.sv
fp_misc_unit.sv
fp_misc_assertions.sv
tb_fp_misc_unit.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_fp_misc_unit
FILELIST := compile.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== tb_fp_misc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module tb_fp_misc_unit;
    import fpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    logic     clk_i;
    logic     reset_i;
    logic     req_i;
    fpu_op_t  op_i;
    fp_word_t frs1_i;
    fp_word_t frs2_i;
    logic     ack_o;
    fp_word_t result_o;

    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    fp_misc_unit u_dut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .frs1_i   (frs1_i),
        .frs2_i   (frs2_i),
        .ack_o    (ack_o),
        .result_o (result_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // exact single-precision image of an integer below 2^24 in magnitude
    function automatic logic [31:0] exact_float(input logic [31:0] v);
        logic [31:0] mag;
        logic [31:0] frac;
        logic [7:0]  exp_b;
        int          lead;
        mag = v[31] ? (~v + 32'd1) : v;
        lead = 0;
        for (int i = 0; i < 32; i++)
        begin
            if (mag[i])
                lead = i;
        end
        frac = (lead > 23) ? (mag >> (lead - 23)) : (mag << (23 - lead));
        exp_b = 8'(127 + lead);
        return (mag == 32'd0) ? 32'd0 : {v[31], exp_b, frac[22:0]};
    endfunction

    task automatic check_word(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        checks++;
        if (got !== want)
        begin
            $display("FAIL %s: expected %h, actual %h", name, want, got);
            errors++;
        end
    endtask

    // one full four-phase transaction starting 1 ns after a rising edge
    task automatic do_op(input fpu_op_t op, input fp_word_t a, input fp_word_t b,
                         output fp_word_t res);
        int waited;
        op_i = op;
        frs1_i = a;
        frs2_i = b;
        req_i = 1'b1;
        waited = 0;
        while (!ack_o && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!ack_o)
        begin
            $display("timeout: ack_o never rose for operation %0d", op);
            errors++;
        end
        res = result_o;
        req_i = 1'b0;
        waited = 0;
        while (ack_o && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (ack_o)
        begin
            $display("timeout: ack_o stayed high after req_i dropped");
            errors++;
        end
    endtask

    task automatic run_case(input string name, input fpu_op_t op, input fp_word_t a,
                            input fp_word_t b, input fp_word_t want);
        fp_word_t got;
        do_op(op, a, b, got);
        check_word(name, want, got);
    endtask

    task automatic handshake_and_hold();
        int edges;
        check_word("reset ack", 32'd0, {31'd0, ack_o});
        check_word("reset result", 32'd0, result_o);
        op_i = `FPU_OP_FMV;
        frs1_i = 32'h1234_5678;
        frs2_i = 32'h0;
        req_i = 1'b1;
        edges = 0;
        while (!ack_o && edges < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            #1;
            edges++;
        end
        if (!ack_o)
        begin
            $display("timeout: ack_o never rose in the handshake test");
            errors++;
        end
        check_word("handshake latency", 32'd3, edges);
        check_word("handshake result", 32'h1234_5678, result_o);
        // requester holds req so the unit holds ack and result
        repeat (10)
        begin
            @(posedge clk_i);
            #1;
            check_word("held ack", 32'd1, {31'd0, ack_o});
            check_word("held result", 32'h1234_5678, result_o);
        end
        req_i = 1'b0;
        edges = 0;
        while (ack_o && edges < TIMEOUT_CYCLES)
        begin
            @(posedge clk_i);
            #1;
            edges++;
        end
        if (ack_o)
        begin
            $display("timeout: ack_o did not fall after req_i dropped");
            errors++;
        end
        // ack falls on the first edge that samples req low
        check_word("release latency", 32'd1, edges);
    endtask

    task automatic move_and_sign_ops();
        fp_word_t a;
        fp_word_t b;
        for (int i = 0; i < 8; i++)
        begin
            a = next_random();
            b = next_random();
            run_case("fmv", `FPU_OP_FMV, a, b, a);
            run_case("fsgnj", `FPU_OP_FSGNJ, a, b, {b[31], a[30:0]});
            run_case("fsgnjn", `FPU_OP_FSGNJN, a, b, {~b[31], a[30:0]});
            run_case("fsgnjx", `FPU_OP_FSGNJX, a, b, {a[31] ^ b[31], a[30:0]});
        end
    endtask

    // want holds feq, flt and fle from high bit to low bit
    task automatic compare_case(input string name, input fp_word_t a, input fp_word_t b,
                                input logic [2:0] want);
        run_case({name, " feq"}, `FPU_OP_FEQ, a, b, {31'd0, want[2]});
        run_case({name, " flt"}, `FPU_OP_FLT, a, b, {31'd0, want[1]});
        run_case({name, " fle"}, `FPU_OP_FLE, a, b, {31'd0, want[0]});
    endtask

    task automatic compare_ops();
        compare_case("1 vs 2", 32'h3f80_0000, 32'h4000_0000, 3'b011);
        compare_case("2 vs 1", 32'h4000_0000, 32'h3f80_0000, 3'b000);
        compare_case("-2 vs -1", 32'hc000_0000, 32'hbf80_0000, 3'b011);
        compare_case("-1 vs -2", 32'hbf80_0000, 32'hc000_0000, 3'b000);
        compare_case("-1 vs 1", 32'hbf80_0000, 32'h3f80_0000, 3'b011);
        compare_case("+0 vs -0", 32'h0000_0000, 32'h8000_0000, 3'b101);
        compare_case("-0 vs +0", 32'h8000_0000, 32'h0000_0000, 3'b101);
        compare_case("2 vs 2", 32'h4000_0000, 32'h4000_0000, 3'b101);
        compare_case("-inf vs +inf", 32'hff80_0000, 32'h7f80_0000, 3'b011);
        compare_case("+inf vs +inf", 32'h7f80_0000, 32'h7f80_0000, 3'b101);
        compare_case("1 vs +inf", 32'h3f80_0000, 32'h7f80_0000, 3'b011);
        compare_case("qnan vs 1", 32'h7fc0_0000, 32'h3f80_0000, 3'b000);
        compare_case("1 vs snan", 32'h3f80_0000, 32'h7f80_0001, 3'b000);
    endtask

    task automatic classify_ops();
        fp_word_t reps [10];
        // in mask order from -inf up to quiet nan
        reps = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
                 32'h0000_0000, 32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000,
                 32'h7f80_0001, 32'h7fc0_0000};
        for (int i = 0; i < 10; i++)
            run_case($sformatf("fclass %0d", i), `FPU_OP_FCLASS, reps[i], '0, 32'd1 << i);
    endtask

    task automatic float_to_int_ops();
        run_case("fcvt.w.s 2.75", `FPU_OP_FCVT_W_S, 32'h4030_0000, '0, 32'd2);
        run_case("fcvt.w.s -2.75", `FPU_OP_FCVT_W_S, 32'hc030_0000, '0, 32'hffff_fffe);
        run_case("fcvt.w.s 3e9", `FPU_OP_FCVT_W_S, 32'h4f32_d05e, '0, 32'h7fff_ffff);
        run_case("fcvt.w.s -3e9", `FPU_OP_FCVT_W_S, 32'hcf32_d05e, '0, 32'h8000_0000);
        run_case("fcvt.wu.s 3e9", `FPU_OP_FCVT_WU_S, 32'h4f32_d05e, '0, 32'hb2d0_5e00);
        run_case("fcvt.wu.s -1.5", `FPU_OP_FCVT_WU_S, 32'hbfc0_0000, '0, 32'd0);
        run_case("fcvt.w.s nan", `FPU_OP_FCVT_W_S, 32'h7fc0_0000, '0, 32'h7fff_ffff);
        run_case("fcvt.wu.s nan", `FPU_OP_FCVT_WU_S, 32'h7fc0_0000, '0, 32'hffff_ffff);
    endtask

    task automatic int_to_float_ops();
        fp_word_t r;
        fp_word_t v;
        fp_word_t f;
        for (int i = 0; i < 8; i++)
        begin
            r = next_random();
            // sign-extended 24-bit value
            v = {{8{r[23]}}, r[23:0]};
            do_op(`FPU_OP_FCVT_S_W, v, '0, f);
            check_word("fcvt.s.w exact", exact_float(v), f);
            run_case("fcvt.w.s round trip", `FPU_OP_FCVT_W_S, f, '0, v);
        end
        run_case("fcvt.s.w tie to even", `FPU_OP_FCVT_S_W, 32'd16777217, '0, 32'h4b80_0000);
        run_case("fcvt.s.w round up", `FPU_OP_FCVT_S_W, 32'd16777219, '0, 32'h4b80_0002);
        run_case("fcvt.s.wu all ones", `FPU_OP_FCVT_S_WU, 32'hffff_ffff, '0, 32'h4f80_0000);
        run_case("fcvt.s.w minus one", `FPU_OP_FCVT_S_W, 32'hffff_ffff, '0, 32'hbf80_0000);
    endtask

    initial
    begin
        reset_i = 1'b1;
        req_i = 1'b0;
        op_i = '0;
        frs1_i = '0;
        frs2_i = '0;
        lcg_state = 32'hbc86_d25e;
        errors = 0;
        checks = 0;
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        handshake_and_hold();
        move_and_sign_ops();
        compare_ops();
        classify_ops();
        float_to_int_ops();
        int_to_float_ops();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fp_misc_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_misc_assertions (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 req_i,
    input logic                 ack_i,
    input fpu_pkg::fp_word_t    result_i,
    input fpu_pkg::hs_state_e   state_i
);
    import fpu_pkg::*;

    // a reset cycle clears ack on its edge
    ack_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !ack_i)
        else $error("ack_o high after a reset cycle");

    // accepted at edge N, ack set at N+2, seen as a rise one sample later
    ack_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_i) |-> $past((state_i == HS_IDLE) && req_i, 3))
        else $error("ack_o rose without an accepted request two edges before");

    ack_held: assert property (@(posedge clk_i) disable iff (reset_i)
        (ack_i && req_i) |=> ack_i)
        else $error("ack_o dropped while req_i was still high");

    result_held: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i |=> $stable(result_i))
        else $error("result_o changed while ack_o was high");

endmodule

bind fp_misc_unit fp_misc_assertions u_assertions (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .result_i (result_o),
    .state_i  (state_q)
);

`default_nettype wire

// ==== fp_misc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fp_misc_unit (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_i,
    input  fpu_pkg::fpu_op_t  op_i,
    input  fpu_pkg::fp_word_t frs1_i,
    input  fpu_pkg::fp_word_t frs2_i,
    output logic              ack_o,
    output fpu_pkg::fp_word_t result_o
);
    import fpu_pkg::*;

    hs_state_e state_q;
    hs_state_e state_d;
    fpu_op_t   op_q;
    fp_word_t  frs1_q;
    fp_word_t  frs2_q;
    fp_word_t  fiu_result;
    fp_word_t  result_q;
    logic      ack_q;

    // next state of the handshake
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            HS_IDLE:
                if (req_i)
                    state_d = HS_CALC;
            HS_CALC:
                state_d = HS_ACK;
            HS_ACK:
                if (!req_i)
                    state_d = HS_IDLE;
            default:
                state_d = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            state_q  <= HS_IDLE;
            ack_q    <= 1'b0;
            result_q <= {`FPU_WORD_W{1'b0}};
        end
        else
        begin
            state_q <= state_d;
            // ack rises one edge after HS_ACK is entered, falls with req low
            ack_q   <= (state_q == HS_ACK) && req_i;
            if (state_q == HS_CALC)
                result_q <= fiu_result;
        end
    end

    // operands captured on an accepted request
    always_ff @(posedge clk_i)
    begin
        if ((state_q == HS_IDLE) && req_i)
        begin
            op_q   <= op_i;
            frs1_q <= frs1_i;
            frs2_q <= frs2_i;
        end
    end

    fiu u_fiu (
        .op_i     (op_q),
        .frs1_i   (frs1_q),
        .frs2_i   (frs2_q),
        .result_o (fiu_result)
    );

    assign ack_o    = ack_q;
    assign result_o = result_q;

endmodule

`default_nettype wire

// ==== fiu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fiu (
    input  fpu_pkg::fpu_op_t  op_i,
    input  fpu_pkg::fp_word_t frs1_i,
    input  fpu_pkg::fp_word_t frs2_i,
    output fpu_pkg::fp_word_t result_o
);
    import fpu_pkg::*;

    logic         s1;
    logic         s2;
    fp_exp_t      e1;
    fp_exp_t      e2;
    fp_mant_t     m1;
    fp_mant_t     m2;
    logic         zero1;
    logic         zero2;
    logic         sub1;
    logic         norm1;
    logic         inf1;
    logic         nan1;
    logic         nan2;
    logic         any_nan;
    logic         both_zero;
    logic         bits_eq;
    logic         mag_lt;
    logic         mag_gt;
    logic         flt_raw;
    logic         feq;
    logic         flt;
    logic         fle;
    fclass_mask_t class_mask;
    int_word_t    cvt_result;
    fp_word_t     result;

    // field split
    assign s1 = frs1_i[`FPU_WORD_W-1];
    assign s2 = frs2_i[`FPU_WORD_W-1];
    assign e1 = frs1_i[`FPU_WORD_W-2:`FPU_MANT_W];
    assign e2 = frs2_i[`FPU_WORD_W-2:`FPU_MANT_W];
    assign m1 = frs1_i[`FPU_MANT_W-1:0];
    assign m2 = frs2_i[`FPU_MANT_W-1:0];

    // operand kinds
    assign zero1 = (e1 == '0) && (m1 == '0);
    assign zero2 = (e2 == '0) && (m2 == '0);
    assign sub1  = (e1 == '0) && (m1 != '0);
    assign norm1 = (e1 != '0) && (e1 != '1);
    assign inf1  = (e1 == '1) && (m1 == '0);
    assign nan1  = (e1 == '1) && (m1 != '0);
    assign nan2  = (e2 == '1) && (m2 != '0);

    assign any_nan   = nan1 || nan2;
    assign both_zero = zero1 && zero2;
    assign bits_eq   = (frs1_i == frs2_i);

    // magnitude order ignoring the sign bit
    assign mag_lt = frs1_i[`FPU_WORD_W-2:0] < frs2_i[`FPU_WORD_W-2:0];
    assign mag_gt = frs2_i[`FPU_WORD_W-2:0] < frs1_i[`FPU_WORD_W-2:0];

    // differing signs decide alone, negatives reverse the magnitude order
    assign flt_raw = (s1 != s2) ? s1 : (s1 ? mag_gt : mag_lt);

    assign feq = !any_nan && (bits_eq || both_zero);
    // +0 and -0 are never less than each other
    assign flt = !any_nan && !both_zero && flt_raw;
    assign fle = feq || flt;

    // one-hot class of frs1, quiet nan by the top mantissa bit
    assign class_mask[0] = s1 && inf1;
    assign class_mask[1] = s1 && norm1;
    assign class_mask[2] = s1 && sub1;
    assign class_mask[3] = s1 && zero1;
    assign class_mask[4] = !s1 && zero1;
    assign class_mask[5] = !s1 && sub1;
    assign class_mask[6] = !s1 && norm1;
    assign class_mask[7] = !s1 && inf1;
    assign class_mask[8] = nan1 && !m1[`FPU_MANT_W-1];
    assign class_mask[9] = nan1 && m1[`FPU_MANT_W-1];

    fiu_cvt u_cvt (
        .op_i     (op_i),
        .frs1_i   (frs1_i),
        .result_o (cvt_result)
    );

    always_comb
    begin
        result = '0;
        case (op_i)
            `FPU_OP_FMV:
                result = frs1_i;
            `FPU_OP_FEQ:
                result = {{(`FPU_WORD_W-1){1'b0}}, feq};
            `FPU_OP_FLT:
                result = {{(`FPU_WORD_W-1){1'b0}}, flt};
            `FPU_OP_FLE:
                result = {{(`FPU_WORD_W-1){1'b0}}, fle};
            `FPU_OP_FSGNJ:
                result = {s2, e1, m1};
            `FPU_OP_FSGNJN:
                result = {~s2, e1, m1};
            `FPU_OP_FSGNJX:
                result = {s1 ^ s2, e1, m1};
            `FPU_OP_FCLASS:
                result = {{(`FPU_WORD_W-$bits(fclass_mask_t)){1'b0}}, class_mask};
            `FPU_OP_FCVT_W_S,
            `FPU_OP_FCVT_WU_S,
            `FPU_OP_FCVT_S_W,
            `FPU_OP_FCVT_S_WU:
                result = cvt_result;
            default:
                result = '0;
        endcase
    end

    assign result_o = result;

endmodule

`default_nettype wire

// ==== fiu_cvt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_params.svh"

module fiu_cvt (
    input  fpu_pkg::fpu_op_t  op_i,
    input  fpu_pkg::fp_word_t frs1_i,
    output fpu_pkg::int_word_t result_o
);
    import fpu_pkg::*;

    logic        sgn;
    fp_exp_t     exp_in;
    fp_mant_t    mant_in;
    logic        is_nan;
    logic        below_one;
    logic        ovf_w;
    logic        ovf_wu;
    fp_exp_t     exp_off;
    logic [4:0]  shamt;
    logic [63:0] shifted;
    int_word_t   mag;
    int_word_t   w_res;
    int_word_t   wu_res;

    logic        neg_in;
    int_word_t   abs_val;
    logic [4:0]  lead;
    int_word_t   norm;
    logic        guard;
    logic        sticky;
    logic        round_up;
    logic [23:0] mant_sum;
    fp_exp_t     f_exp;
    fp_word_t    f_res;

    // float to integer
    assign sgn     = frs1_i[`FPU_WORD_W-1];
    assign exp_in  = frs1_i[`FPU_WORD_W-2:`FPU_MANT_W];
    assign mant_in = frs1_i[`FPU_MANT_W-1:0];
    assign is_nan  = (exp_in == '1) && (mant_in != '0);

    // below 1.0 truncates to zero, 2^31 and up no longer fits the signed form
    assign below_one = exp_in < 8'd127;
    assign ovf_w     = exp_in >= 8'd158;
    assign ovf_wu    = exp_in >= 8'd159;

    assign exp_off = exp_in - 8'd127;
    assign shamt   = exp_off[4:0];
    // restored mantissa, binary point sits at bit 23
    assign shifted = {40'b0, 1'b1, mant_in} << shamt;
    assign mag     = below_one ? '0 : shifted[54:23];

    always_comb
    begin
        if (is_nan)
            w_res = 32'h7fff_ffff;
        else if (sgn)
            w_res = ovf_w ? 32'h8000_0000 : (~mag + 32'd1);
        else
            w_res = ovf_w ? 32'h7fff_ffff : mag;
    end

    always_comb
    begin
        if (is_nan)
            wu_res = 32'hffff_ffff;
        else if (sgn)
            wu_res = '0;
        else
            wu_res = ovf_wu ? 32'hffff_ffff : mag;
    end

    // integer to float
    assign neg_in  = (op_i == `FPU_OP_FCVT_S_W) && frs1_i[`FPU_WORD_W-1];
    assign abs_val = neg_in ? (~frs1_i + 32'd1) : frs1_i;

    // position of the leading one
    always_comb
    begin
        lead = '0;
        for (int i = 0; i < `FPU_WORD_W; i++)
        begin
            if (abs_val[i])
                lead = 5'(i);
        end
    end

    assign norm = abs_val << (5'd31 - lead);

    // nearest even on the eight dropped bits
    assign guard    = norm[7];
    assign sticky   = |norm[6:0];
    assign round_up = guard && (sticky || norm[8]);

    // carry out of the mantissa bumps the exponent
    assign mant_sum = {1'b0, norm[30:8]} + {23'b0, round_up};
    assign f_exp    = 8'd127 + {3'b0, lead} + {7'b0, mant_sum[23]};
    assign f_res    = (abs_val == '0) ? '0 : {neg_in, f_exp, mant_sum[22:0]};

    always_comb
    begin
        case (op_i)
            `FPU_OP_FCVT_W_S:
                result_o = w_res;
            `FPU_OP_FCVT_WU_S:
                result_o = wu_res;
            `FPU_OP_FCVT_S_W,
            `FPU_OP_FCVT_S_WU:
                result_o = f_res;
            default:
                result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== fpu_pkg.sv ====
`default_nettype none

`include "fpu_params.svh"

package fpu_pkg;

    // one single-precision value
    typedef logic [`FPU_WORD_W-1:0] fp_word_t;

    // one integer operand or result
    typedef logic [`FPU_WORD_W-1:0] int_word_t;

    // biased exponent and stored mantissa fields
    typedef logic [`FPU_EXP_W-1:0] fp_exp_t;
    typedef logic [`FPU_MANT_W-1:0] fp_mant_t;

    // decoded operation code
    typedef logic [`FPU_OP_W-1:0] fpu_op_t;

    // fclass one-hot mask, bit 0 is -inf up to bit 7 +inf
    // bit 8 signaling nan, bit 9 quiet nan
    typedef logic [9:0] fclass_mask_t;

    // four-phase handshake states
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_CALC,
        HS_ACK
    } hs_state_e;

endpackage

`default_nettype wire

// ==== fpu_params.svh ====
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// data and field widths of a single-precision word
`define FPU_WORD_W 32
`define FPU_EXP_W 8
`define FPU_MANT_W 23

// operation code width
`define FPU_OP_W 4

// decoded operation codes, 12 to 15 unused
`define FPU_OP_FMV 4'd0
`define FPU_OP_FEQ 4'd1
`define FPU_OP_FLT 4'd2
`define FPU_OP_FLE 4'd3
`define FPU_OP_FSGNJ 4'd4
`define FPU_OP_FSGNJN 4'd5
`define FPU_OP_FSGNJX 4'd6
`define FPU_OP_FCLASS 4'd7
`define FPU_OP_FCVT_W_S 4'd8
`define FPU_OP_FCVT_WU_S 4'd9
`define FPU_OP_FCVT_S_W 4'd10
`define FPU_OP_FCVT_S_WU 4'd11

`endif
